// ==== vlog.f ====
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_way.sv
logic/four_bank_mem.sv
logic/cache_ctrl_assoc.sv
logic/mem_system.sv
tests/mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: mem_system

sources:
  - logic/cache_pkg.sv
  - logic/mem_pkg.sv
  - logic/cache_way.sv
  - logic/four_bank_mem.sv
  - logic/cache_ctrl_assoc.sv
  - logic/mem_system.sv
  - target: test
    files:
      - tests/mem_system_tb.sv

// ==== tests/mem_system_tb.sv ====
// Testbench for mem_system with clock, reset, request tasks, shadow model and timing checks
`default_nettype none

module mem_system_tb;
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int TB_LATENCY = 3;
   localparam int TB_BUSY    = 5;
   localparam int MAX_WAIT   = 200;
   localparam int NUM_RANDOM = 300;

   logic              clk = 1'b0;
   logic              rst_n;
   logic [WORD_W-1:0] addr;
   logic [WORD_W-1:0] data_in;
   logic              rd;
   logic              wr;
   wire  [WORD_W-1:0] data_out;
   wire               done;
   wire               stall;
   wire               cache_hit;
   wire               err;

   // Written words and a tag model of both ways
   logic [WORD_W-1:0] shadow [int];
   logic [TAG_W-1:0]  model_tag   [2][1 << INDEX_W];
   bit                model_valid [2][1 << INDEX_W];
   bit                model_victim;

   mem_system #(
      .mem_latency(TB_LATENCY),
      .bank_busy_cycles(TB_BUSY)
   ) mem_system_inst (
      .clk(clk),
      .rst_n(rst_n),
      .Addr(addr),
      .DataIn(data_in),
      .Rd(rd),
      .Wr(wr),
      .DataOut(data_out),
      .Done(done),
      .Stall(stall),
      .CacheHit(cache_hit),
      .err(err)
   );

   always #10 clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("ERROR at time %0t: %s", $time, msg);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else report_mismatch("Done high for more than one cycle");
   a_stall_rise: assert property (@(posedge clk) disable iff (!rst_n)
                                  (!stall && (rd || wr)) |=> stall)
      else report_mismatch("Stall not raised in the cycle after capture");
   a_stall_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                  (!stall && !rd && !wr) |=> !stall)
      else report_mismatch("Stall raised without a request");
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n) (stall && !done) |=> stall)
      else report_mismatch("Stall dropped before Done");
   a_done_stall: assert property (@(posedge clk) disable iff (!rst_n) done |-> stall)
      else report_mismatch("Done outside of Stall");
   a_stall_fall: assert property (@(posedge clk) disable iff (!rst_n) done |=> !stall)
      else report_mismatch("Stall still high after Done");
   a_flag_done: assert property (@(posedge clk) disable iff (!rst_n)
                                 (err || cache_hit) |-> done)
      else report_mismatch("err or CacheHit high without Done");

   // Address is tag | index | word | byte
   function automatic logic [WORD_W-1:0] make_addr(input int tag, input int idx, input int word);
      return {TAG_W'(tag), INDEX_W'(idx), 2'(word), 1'b0};
   endfunction

   function automatic bit model_holds(input logic [WORD_W-1:0] a);
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]   tag;
      idx = a[OFFSET_W +: INDEX_W];
      tag = a[WORD_W-1 -: TAG_W];
      return (model_valid[0][idx] && model_tag[0][idx] == tag) ||
             (model_valid[1][idx] && model_tag[1][idx] == tag);
   endfunction

   // Victim flips on every captured request before the lookup
   function automatic bit predict_hit(input logic [WORD_W-1:0] a, input bit is_err);
      logic [INDEX_W-1:0] idx;
      bit                 way;
      bit                 hit;
      idx          = a[OFFSET_W +: INDEX_W];
      model_victim = ~model_victim;
      hit          = !is_err && model_holds(a);
      if (!is_err && !hit) begin
         if (!model_valid[0][idx]) begin
            way = 1'b0;
         end else if (!model_valid[1][idx]) begin
            way = 1'b1;
         end else begin
            way = model_victim;
         end
         model_valid[way][idx] = 1'b1;
         model_tag[way][idx]   = a[WORD_W-1 -: TAG_W];
      end
      return hit;
   endfunction

   task automatic pulse_strobe(input logic rd_v, input logic wr_v,
                               input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] d);
      @(negedge clk);
      rd      = rd_v;
      wr      = wr_v;
      addr    = a;
      data_in = d;
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // Counts extra cycles beyond the first one after capture
   task automatic wait_done(output int cycles);
      cycles = 0;
      while (!done && cycles < MAX_WAIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         $display("TESTS FAILED");
         $display("No Done from the DUT within %0d cycles of a request", MAX_WAIT);
         $fatal(1, "Simulation stopped on a timeout");
      end
   endtask

   task automatic run_request(input logic rd_v, input logic wr_v,
                              input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] d);
      bit exp_err;
      bit exp_hit;
      int cycles;
      int key;
      exp_err = a[0] | (rd_v & wr_v);
      exp_hit = predict_hit(a, exp_err);
      key     = int'(a);
      pulse_strobe(rd_v, wr_v, a, d);
      wait_done(cycles);
      if (exp_err) begin
         assert (err && !cache_hit && cycles == 0)
            else report_mismatch($sformatf("bad request %h: err=%b hit=%b extra cycles=%0d",
                                           a, err, cache_hit, cycles));
      end else begin
         assert (!err)
            else report_mismatch($sformatf("err set for valid request %h", a));
         assert (cache_hit == exp_hit && (cycles == 0) == exp_hit)
            else report_mismatch($sformatf("addr %h: CacheHit=%b expected %b, extra cycles=%0d",
                                           a, cache_hit, exp_hit, cycles));
         if (rd_v && shadow.exists(key)) begin
            assert (data_out === shadow[key])
               else report_mismatch($sformatf("read %h returned %h, expected %h",
                                              a, data_out, shadow[key]));
         end
         if (wr_v) begin
            shadow[key] = d;
         end
      end
   endtask

   task automatic do_read(input logic [WORD_W-1:0] a);
      run_request(1'b1, 1'b0, a, '0);
   endtask

   task automatic do_write(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] d);
      run_request(1'b0, 1'b1, a, d);
   endtask

   // Strobe lands in the Done cycle while Stall is high
   task automatic stray_strobe(input logic [WORD_W-1:0] a);
      wr      = 1'b1;
      addr    = a;
      data_in = 16'hF00D;
      @(negedge clk);
      wr = 1'b0;
      repeat (6) begin
         @(negedge clk);
         assert (!done && !stall)
            else report_mismatch("ignored strobe produced Done or Stall");
      end
   endtask

   initial begin
      logic [WORD_W-1:0] a0;
      logic [WORD_W-1:0] a3;
      logic [WORD_W-1:0] ra;
      int                t;
      void'($urandom(25695));
      rst_n        = 1'b0;
      addr         = '0;
      data_in      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      model_victim = 1'b0;

      repeat (16) begin
         @(negedge clk);
         assert (!done && !stall && !cache_hit && !err && mem_system_inst.mem_op == MEM_NOP)
            else report_mismatch("outputs not low during reset");
      end
      rst_n = 1'b1;

      // First touch misses and the repeat hits
      do_read(make_addr(2, 6, 0));
      a0 = make_addr(1, 5, 2);
      do_write(a0, 16'h1234);
      do_read(a0);
      do_write(make_addr(2, 6, 0), 16'h0F0F);
      do_read(make_addr(2, 6, 0));

      // Three tags on one index force a dirty eviction
      do_write(make_addr(3, 20, 0), 16'h3003);
      do_write(make_addr(7, 20, 1), 16'h7007);
      do_write(make_addr(12, 20, 3), 16'hC00C);
      do_read(make_addr(3, 20, 0));
      do_read(make_addr(7, 20, 1));
      do_read(make_addr(12, 20, 3));

      // Dirty hit survives eviction and refill
      a3 = make_addr(4, 30, 1);
      do_read(a3);
      do_write(a3, 16'h5555);
      t = 9;
      while (model_holds(a3) && t < 32) begin
         do_write(make_addr(t, 30, 1), 16'(t));
         t = t + 5;
      end
      do_read(a3);

      // Bad requests touch nothing
      run_request(1'b0, 1'b1, a0 | 16'h1, 16'hDEAD);
      run_request(1'b1, 1'b0, a0 | 16'h1, '0);
      run_request(1'b1, 1'b1, a0, 16'hBEEF);
      do_read(a0);

      // Strobes during Stall on a hit and on a miss
      do_read(a0);
      stray_strobe(a0);
      do_read(make_addr(6, 40, 0));
      stray_strobe(a0);
      do_read(a0);

      for (int n = 0; n < NUM_RANDOM; n++) begin
         ra = make_addr(3 + 7 * $urandom_range(0, 3), 8 + 3 * $urandom_range(0, 7),
                        $urandom_range(0, 3));
         if ($urandom_range(0, 1) == 1) begin
            do_write(ra, 16'($urandom));
         end else begin
            do_read(ra);
         end
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/mem_system.sv ====
// Top level with two cache ways, the cache controller and the four-bank memory
`default_nettype none

module mem_system #(
   parameter int mem_latency      = mem_pkg::DEF_MEM_LATENCY,
   parameter int bank_busy_cycles = mem_pkg::DEF_BANK_BUSY
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire [cache_pkg::WORD_W-1:0]  Addr,
   input  wire [cache_pkg::WORD_W-1:0]  DataIn,
   input  wire                          Rd,
   input  wire                          Wr,
   output wire [cache_pkg::WORD_W-1:0]  DataOut,
   output wire                          Done,
   output wire                          Stall,
   output wire                          CacheHit,
   output wire                          err
);
   import cache_pkg::*;
   import mem_pkg::*;

   wire                way0_hit;
   wire                way0_valid;
   wire                way0_dirty;
   wire                way1_hit;
   wire                way1_valid;
   wire                way1_dirty;
   wire [TAG_W-1:0]    way0_tag;
   wire [TAG_W-1:0]    way1_tag;
   wire [WORD_W-1:0]   way0_data;
   wire [WORD_W-1:0]   way1_data;
   wire [1:0]          way_en;
   wire [TAG_W-1:0]    tag_in;
   wire [INDEX_W-1:0]  index;
   wire [OFFSET_W-1:0] offset;
   wire [WORD_W-1:0]   way_wdata;
   wire                comp;
   wire                write;
   wire                valid_in;
   wire                dirty_in;
   wire mem_op_e       mem_op;
   wire [WORD_W-1:0]   mem_addr;
   wire [WORD_W-1:0]   mem_wdata;
   wire [WORD_W-1:0]   mem_rdata;
   wire                mem_stall;
   wire                mem_rvalid;

   cache_way way0 (
      .clk(clk), .rst_n(rst_n), .enable(way_en[0]), .tag_in(tag_in), .index(index),
      .offset(offset), .data_in(way_wdata), .comp(comp), .write(write),
      .valid_in(valid_in), .dirty_in(dirty_in), .tag_out(way0_tag), .data_out(way0_data),
      .hit(way0_hit), .dirty(way0_dirty), .valid(way0_valid)
   );

   cache_way way1 (
      .clk(clk), .rst_n(rst_n), .enable(way_en[1]), .tag_in(tag_in), .index(index),
      .offset(offset), .data_in(way_wdata), .comp(comp), .write(write),
      .valid_in(valid_in), .dirty_in(dirty_in), .tag_out(way1_tag), .data_out(way1_data),
      .hit(way1_hit), .dirty(way1_dirty), .valid(way1_valid)
   );

   cache_ctrl_assoc #(.mem_latency(mem_latency)) control (
      .clk(clk), .rst_n(rst_n), .addr(Addr), .data_in(DataIn), .rd(Rd), .wr(Wr),
      .data_out(DataOut), .done(Done), .stall(Stall), .cache_hit(CacheHit), .err(err),
      .way0_hit(way0_hit), .way0_valid(way0_valid), .way0_dirty(way0_dirty),
      .way0_tag(way0_tag), .way0_data(way0_data),
      .way1_hit(way1_hit), .way1_valid(way1_valid), .way1_dirty(way1_dirty),
      .way1_tag(way1_tag), .way1_data(way1_data),
      .way_en(way_en), .tag_in(tag_in), .index(index), .offset(offset),
      .way_wdata(way_wdata), .comp(comp), .write(write), .valid_in(valid_in),
      .dirty_in(dirty_in), .mem_stall(mem_stall), .mem_rdata(mem_rdata),
      .mem_rvalid(mem_rvalid), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
   );

   four_bank_mem #(
      .mem_latency(mem_latency),
      .bank_busy_cycles(bank_busy_cycles)
   ) mem (
      .clk(clk), .rst_n(rst_n), .mem_op(mem_op), .addr(mem_addr), .wdata(mem_wdata),
      .rdata(mem_rdata), .rvalid(mem_rvalid), .stall(mem_stall), .busy()
   );

endmodule

`default_nettype wire

// ==== logic/cache_ctrl_assoc.sv ====
// Cache controller: miss FSM, way selection, victim choice, write-back, fill, requester outputs
`default_nettype none

module cache_ctrl_assoc #(
   parameter int mem_latency = 2
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire [cache_pkg::WORD_W-1:0]    addr,
   input  wire [cache_pkg::WORD_W-1:0]    data_in,
   input  wire                            rd,
   input  wire                            wr,
   output logic [cache_pkg::WORD_W-1:0]   data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err,
   input  wire                            way0_hit,
   input  wire                            way0_valid,
   input  wire                            way0_dirty,
   input  wire [cache_pkg::TAG_W-1:0]     way0_tag,
   input  wire [cache_pkg::WORD_W-1:0]    way0_data,
   input  wire                            way1_hit,
   input  wire                            way1_valid,
   input  wire                            way1_dirty,
   input  wire [cache_pkg::TAG_W-1:0]     way1_tag,
   input  wire [cache_pkg::WORD_W-1:0]    way1_data,
   output logic [1:0]                     way_en,
   output logic [cache_pkg::TAG_W-1:0]    tag_in,
   output logic [cache_pkg::INDEX_W-1:0]  index,
   output logic [cache_pkg::OFFSET_W-1:0] offset,
   output logic [cache_pkg::WORD_W-1:0]   way_wdata,
   output logic                           comp,
   output logic                           write,
   output logic                           valid_in,
   output logic                           dirty_in,
   input  wire                            mem_stall,
   input  wire [cache_pkg::WORD_W-1:0]    mem_rdata,
   input  wire                            mem_rvalid,
   output mem_pkg::mem_op_e               mem_op,
   output logic [cache_pkg::WORD_W-1:0]   mem_addr,
   output logic [cache_pkg::WORD_W-1:0]   mem_wdata
);
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int                WSEL_W = $clog2(WORDS_PER_LINE);
   localparam logic [WSEL_W-1:0] LAST   = WSEL_W'(WORDS_PER_LINE - 1);

   ctrl_state_e       state;
   ctrl_state_e       state_nxt;
   logic [WORD_W-1:0] req_addr;
   logic [WORD_W-1:0] req_data;
   logic              req_wr;
   logic              req_err;
   logic              capture;
   logic              victim;
   logic              sel_way;
   logic              miss_way;
   logic              wb_needed;
   logic              hit_any;
   logic [1:0]        sel_en;
   logic [WSEL_W-1:0] cnt;
   logic [WSEL_W-1:0] ret_cnt;
   logic              cnt_step;
   logic [WSEL_W-1:0] ret_slot [mem_latency];
   logic [WORD_W-1:0] line_buf [WORDS_PER_LINE];
   logic [TAG_W-1:0]  victim_tag;
   logic [WORD_W-1:0] sel_data;
   logic [WORD_W-1:0] rd_result;
   logic [WORD_W-1:0] data_hold;
   logic              rd_done;

   assign capture = (state == ST_IDLE) & (rd | wr);
   assign stall   = (state != ST_IDLE);

   assign tag_in = req_addr[WORD_W-1 -: TAG_W];
   assign index  = req_addr[OFFSET_W +: INDEX_W];

   // First invalid way wins, otherwise the victim flop picks
   assign hit_any   = way0_hit | way1_hit;
   assign miss_way  = ~way0_valid ? 1'b0 : (~way1_valid ? 1'b1 : victim);
   assign wb_needed = way0_valid & way1_valid & (victim ? way1_dirty : way0_dirty);

   assign sel_en     = sel_way ? 2'b10 : 2'b01;
   assign sel_data   = sel_way ? way1_data : way0_data;
   assign victim_tag = sel_way ? way1_tag : way0_tag;
   assign rd_result  = (state == ST_COMPARE) ? (way1_hit ? way1_data : way0_data) : sel_data;

   assign rd_done  = done & ~req_wr & ~err;
   assign data_out = rd_done ? rd_result : data_hold;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         req_wr  <= 1'b0;
         req_err <= 1'b0;
         victim  <= 1'b0;
         sel_way <= 1'b0;
         cnt     <= '0;
         ret_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (capture) begin
            req_wr  <= wr;
            req_err <= addr[0] | (rd & wr);
            victim  <= ~victim;
         end
         if (state == ST_COMPARE) begin
            sel_way <= miss_way;
            cnt     <= '0;
            ret_cnt <= '0;
         end else begin
            if (cnt_step) begin
               cnt <= cnt + 1'b1;
            end
            if (mem_rvalid) begin
               ret_cnt <= ret_cnt + 1'b1;
            end
         end
      end
   end

   // Word offset of each read travels alongside it through the memory latency
   always_ff @(posedge clk) begin
      if (capture) begin
         req_addr <= addr;
         req_data <= data_in;
      end
      ret_slot[0] <= cnt;
      for (int i = 1; i < mem_latency; i++) begin
         ret_slot[i] <= ret_slot[i-1];
      end
      if (mem_rvalid) begin
         line_buf[ret_slot[mem_latency-1]] <= mem_rdata;
      end
      if (rd_done) begin
         data_hold <= rd_result;
      end
   end

   always_comb begin
      state_nxt = state;
      done      = 1'b0;
      cache_hit = 1'b0;
      err       = 1'b0;
      way_en    = 2'b00;
      comp      = 1'b0;
      write     = 1'b0;
      valid_in  = 1'b0;
      dirty_in  = 1'b0;
      offset    = req_addr[OFFSET_W-1:0];
      way_wdata = req_data;
      mem_op    = MEM_NOP;
      mem_addr  = {tag_in, index, cnt, 1'b0};
      mem_wdata = sel_data;
      cnt_step  = 1'b0;
      case (state)
         ST_IDLE: begin
            if (rd || wr) begin
               state_nxt = ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            way_en = 2'b11;
            comp   = 1'b1;
            if (req_err) begin
               done      = 1'b1;
               err       = 1'b1;
               state_nxt = ST_IDLE;
            end else if (hit_any) begin
               write     = req_wr;
               done      = 1'b1;
               cache_hit = 1'b1;
               state_nxt = ST_IDLE;
            end else if (wb_needed) begin
               state_nxt = ST_WB_ISSUE;
            end else begin
               state_nxt = ST_FILL_ISSUE;
            end
         end
         ST_WB_ISSUE, ST_WB_WAIT: begin
            // Victim words are read straight out of the way
            offset   = {cnt, 1'b0};
            mem_op   = MEM_WRITE;
            mem_addr = {victim_tag, index, cnt, 1'b0};
            if (mem_stall) begin
               state_nxt = ST_WB_WAIT;
            end else begin
               cnt_step  = 1'b1;
               state_nxt = (cnt == LAST) ? ST_FILL_ISSUE : ST_WB_ISSUE;
            end
         end
         ST_FILL_ISSUE: begin
            mem_op = MEM_READ;
            if (!mem_stall) begin
               cnt_step = 1'b1;
               if (cnt == LAST) begin
                  state_nxt = ST_FILL_WAIT;
               end
            end
         end
         ST_FILL_WAIT: begin
            if (mem_rvalid && ret_cnt == LAST) begin
               state_nxt = ST_FILL_WRITE;
            end
         end
         ST_FILL_WRITE: begin
            way_en    = sel_en;
            write     = 1'b1;
            valid_in  = 1'b1;
            offset    = {cnt, 1'b0};
            way_wdata = line_buf[cnt];
            cnt_step  = 1'b1;
            if (cnt == LAST) begin
               state_nxt = ST_ACCESS;
            end
         end
         ST_ACCESS: begin
            // Replay the request, a write now hits and sets dirty
            way_en    = sel_en;
            comp      = 1'b1;
            write     = req_wr;
            state_nxt = ST_DONE;
         end
         ST_DONE: begin
            done      = 1'b1;
            state_nxt = ST_IDLE;
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/four_bank_mem.sv ====
// Word-interleaved four-bank memory with per-bank busy timers and fixed read latency
`default_nettype none

module four_bank_mem #(
   parameter int mem_latency      = 2,
   parameter int bank_busy_cycles = 4
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire mem_pkg::mem_op_e          mem_op,
   input  wire [cache_pkg::WORD_W-1:0]    addr,
   input  wire [cache_pkg::WORD_W-1:0]    wdata,
   output logic [cache_pkg::WORD_W-1:0]   rdata,
   output logic                           rvalid,
   output logic                           stall,
   output logic [mem_pkg::NUM_BANKS-1:0]  busy
);
   import cache_pkg::*;
   import mem_pkg::*;

   localparam int BANK_W  = $clog2(NUM_BANKS);
   localparam int CNT_W   = $clog2(bank_busy_cycles + 1);
   localparam int WADDR_W = WORD_W - 1;

   logic [WORD_W-1:0]      mem_array [1 << WADDR_W];
   logic [CNT_W-1:0]       busy_cnt  [NUM_BANKS];
   logic [WORD_W-1:0]      pipe_data [mem_latency];
   logic [mem_latency-1:0] pipe_valid;
   logic [BANK_W-1:0]      bank;
   logic                   accept;
   logic                   rd_accept;

   assign bank = addr[BANK_W:1];

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // A command to a busy bank is refused until the bank frees up
   assign stall     = (mem_op != MEM_NOP) & busy[bank];
   assign accept    = (mem_op != MEM_NOP) & ~busy[bank];
   assign rd_accept = accept & (mem_op == MEM_READ);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && bank == BANK_W'(b)) begin
               busy_cnt[b] <= CNT_W'(bank_busy_cycles);
            end else if (busy[b]) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Read latency pipe, one stage per cycle of latency
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= rd_accept;
         for (int i = 1; i < mem_latency; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_data[0] <= mem_array[addr[WORD_W-1:1]];
      for (int i = 1; i < mem_latency; i++) begin
         pipe_data[i] <= pipe_data[i-1];
      end
      if (accept && mem_op == MEM_WRITE) begin
         mem_array[addr[WORD_W-1:1]] <= wdata;
      end
   end

   assign rdata  = pipe_data[mem_latency-1];
   assign rvalid = pipe_valid[mem_latency-1];

endmodule

`default_nettype wire

// ==== logic/cache_way.sv ====
// One cache way: tag, valid and dirty arrays, line data storage and tag compare
`default_nettype none

module cache_way (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            enable,
   input  wire [cache_pkg::TAG_W-1:0]     tag_in,
   input  wire [cache_pkg::INDEX_W-1:0]   index,
   input  wire [cache_pkg::OFFSET_W-1:0]  offset,
   input  wire [cache_pkg::WORD_W-1:0]    data_in,
   input  wire                            comp,
   input  wire                            write,
   input  wire                            valid_in,
   input  wire                            dirty_in,
   output logic [cache_pkg::TAG_W-1:0]    tag_out,
   output logic [cache_pkg::WORD_W-1:0]   data_out,
   output logic                           hit,
   output logic                           dirty,
   output logic                           valid
);
   import cache_pkg::*;

   localparam int LINES  = 1 << INDEX_W;
   localparam int WSEL_W = $clog2(WORDS_PER_LINE);

   logic [TAG_W-1:0]          tag_mem  [LINES];
   logic [WORD_W-1:0]         data_mem [LINES*WORDS_PER_LINE];
   logic [LINES-1:0]          valid_bits;
   logic [LINES-1:0]          dirty_bits;
   logic [INDEX_W+WSEL_W-1:0] word_addr;
   logic                      do_write;

   // Byte offset bit 0 is ignored, words are 16 bit
   assign word_addr = {index, offset[OFFSET_W-1:1]};

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[word_addr];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign hit      = valid_bits[index] & (tag_mem[index] == tag_in);

   // Compare mode only writes on a hit
   assign do_write = enable & write & (~comp | hit);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_write) begin
         if (comp) begin
            dirty_bits[index] <= 1'b1;
         end else begin
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= dirty_in;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         data_mem[word_addr] <= data_in;
         if (!comp) begin
            tag_mem[index] <= tag_in;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
// Bank count, default bank timing and the memory opcode enum
`default_nettype none

package mem_pkg;

   // Banks are word interleaved on addr[2:1]
   localparam int NUM_BANKS = 4;

   localparam int DEF_MEM_LATENCY = 2;
   localparam int DEF_BANK_BUSY   = 4;

   typedef enum logic [1:0] {
      MEM_NOP,
      MEM_READ,
      MEM_WRITE
   } mem_op_e;

endpackage

`default_nettype wire

// ==== logic/cache_pkg.sv ====
// Cache geometry constants, address field widths and the controller state enum
`default_nettype none

package cache_pkg;

   // Address split is tag | index | byte offset
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int OFFSET_W       = 3;
   localparam int WORD_W         = 16;
   localparam int WORDS_PER_LINE = 4;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WB_ISSUE,
      ST_WB_WAIT,
      ST_FILL_ISSUE,
      ST_FILL_WAIT,
      ST_FILL_WRITE,
      ST_ACCESS,
      ST_DONE
   } ctrl_state_e;

endpackage

`default_nettype wire
